// ==== logic/elevator_pkg.sv ====
// Shared sizes and types; floor numbers are 4 bits, so at most 16 floors are supported
`default_nettype none

package elevator_pkg;

    //////////////////////////////////////////////////////////////////////
    // Default sizes
    //////////////////////////////////////////////////////////////////////

    // Floors served, lowest floor is 0
    localparam int NUM_FLOORS_DEFAULT = 11;

    // Request queue entries, must be a power of two
    localparam int QUEUE_DEPTH_DEFAULT = 16;

    // Bits needed for a floor number
    localparam int FLOOR_WIDTH = 4;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    // Floor number as seen by every block
    typedef logic [FLOOR_WIDTH-1:0] floor_t;

    // Dispatch FSM
    // IDLE waits for a request, TRAVEL holds until the car reaches the target
    typedef enum logic {
        DISPATCH_IDLE   = 1'b0,
        DISPATCH_TRAVEL = 1'b1
    } dispatch_state_t;

endpackage

`default_nettype wire

// ==== logic/request_latch.sv ====
// Buttons are held levels; one press is accepted per cycle, panel before call, lowest floor first
`default_nettype none
`timescale 1ns/100ps

module request_latch #(
    parameter int num_floors = elevator_pkg::NUM_FLOORS_DEFAULT
) (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire  [num_floors-1:0]       floor_call_buttons,
    input  wire  [num_floors-1:0]       panel_buttons,
    input  wire  elevator_pkg::floor_t  current_floor,
    input  wire                         power_switch,
    input  wire                         emergency_btn,
    input  wire                         queue_full,
    input  wire                         arrival,
    output logic [num_floors-1:0]       call_button_lights,
    output logic [num_floors-1:0]       panel_button_lights,
    output logic                        request_valid,
    output elevator_pkg::floor_t        request_floor
);

    logic [num_floors-1:0] here_mask;
    logic [num_floors-1:0] clear_mask;
    logic [num_floors-1:0] panel_ok;
    logic [num_floors-1:0] call_ok;
    logic [num_floors-1:0] panel_set;
    logic [num_floors-1:0] call_set;
    logic                  accept_en;
    logic                  panel_hit;
    logic                  call_hit;
    elevator_pkg::floor_t  panel_floor;
    elevator_pkg::floor_t  call_floor;

    // Lowest set bit of a button vector as a floor number
    function automatic elevator_pkg::floor_t lowest_floor(input logic [num_floors-1:0] vec);
        elevator_pkg::floor_t result;
        result = '0;
        for (int i = num_floors - 1; i >= 0; i--) begin
            if (vec[i]) begin
                result = elevator_pkg::floor_t'(i);
            end
        end
        return result;
    endfunction

    // One-hot position of the car
    always_comb begin
        for (int i = 0; i < num_floors; i++) begin
            here_mask[i] = (current_floor == elevator_pkg::floor_t'(i));
        end
    end

    // A press counts only if its light is dark and the car is elsewhere
    assign panel_ok = panel_buttons & ~panel_button_lights & ~here_mask;
    assign call_ok  = floor_call_buttons & ~call_button_lights & ~here_mask;

    assign accept_en   = power_switch && !emergency_btn && !queue_full;
    assign panel_hit   = |panel_ok;
    assign call_hit    = |call_ok;
    assign panel_floor = lowest_floor(panel_ok);
    assign call_floor  = lowest_floor(call_ok);

    // Request pulse goes straight into the queue at this edge
    assign request_valid = accept_en && (panel_hit || call_hit);
    assign request_floor = panel_hit ? panel_floor : call_floor;

    // Call press loses to a panel press and retries while held
    always_comb begin
        for (int i = 0; i < num_floors; i++) begin
            panel_set[i] = accept_en && panel_hit &&
                           (panel_floor == elevator_pkg::floor_t'(i));
            call_set[i]  = accept_en && !panel_hit && call_hit &&
                           (call_floor == elevator_pkg::floor_t'(i));
        end
    end

    assign clear_mask = arrival ? here_mask : '0;

    //////////////////////////////////////////////////////////////////////
    // Request lights
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
        end else if (!power_switch) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
        end else begin
            panel_button_lights <= (panel_button_lights | panel_set) & ~clear_mask;
            call_button_lights  <= (call_button_lights | call_set) & ~clear_mask;
        end
    end

endmodule

`default_nettype wire

// ==== logic/request_queue.sv ====
// Circular request FIFO; depth must be a power of two, and a push while full is dropped
`default_nettype none
`timescale 1ns/100ps

module request_queue #(
    parameter int queue_depth = elevator_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire                         request_valid,
    input  wire  elevator_pkg::floor_t  request_floor,
    input  wire                         arrival,
    input  wire                         power_switch,
    output elevator_pkg::floor_t        head_floor,
    output logic                        queue_empty,
    output logic                        queue_full
);

    localparam int ptr_width   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_width = $clog2(queue_depth + 1);

    elevator_pkg::floor_t   entries [queue_depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   push;
    logic                   pop;

    // Pointer advance with wrap at the last entry
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        logic [ptr_width-1:0] result;
        if (ptr == ptr_width'(queue_depth - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    assign push        = request_valid && !queue_full;
    assign pop         = arrival && !queue_empty;
    assign queue_empty = (count == '0);
    assign queue_full  = (count == count_width'(queue_depth));
    assign head_floor  = entries[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            entries[wr_ptr] <= request_floor;
        end
    end

    // Power off flushes by rewinding the pointers
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (!power_switch) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/dispatch_control.sv ====
// Serves the queue head in order; arrival needs the car stopped at the target, doors need it stopped
`default_nettype none
`timescale 1ns/100ps

module dispatch_control #(
    parameter int num_floors = elevator_pkg::NUM_FLOORS_DEFAULT
) (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire  elevator_pkg::floor_t  head_floor,
    input  wire                         queue_empty,
    input  wire  elevator_pkg::floor_t  current_floor,
    input  wire                         elevator_moving,
    input  wire                         power_switch,
    input  wire                         emergency_btn,
    input  wire                         door_open_btn,
    input  wire                         door_close_btn,
    output elevator_pkg::floor_t        target_floor,
    output logic                        direction_up,
    output logic                        activate_elevator,
    output logic                        arrival,
    output logic                        door_open_allowed,
    output logic                        door_close_allowed
);

    elevator_pkg::dispatch_state_t state;

    logic run_en;
    logic head_in_range;
    logic head_here;
    logic start_travel;
    logic arrival_idle;
    logic arrival_travel;
    logic door_gate;

    assign run_en        = power_switch && !emergency_btn;
    assign head_in_range = int'(head_floor) < num_floors;
    assign head_here     = (head_floor == current_floor);
    assign start_travel  = !queue_empty && head_in_range && !head_here;

    // Head already here, or a bad floor number, is retired without a trip
    assign arrival_idle   = (state == elevator_pkg::DISPATCH_IDLE) && !queue_empty &&
                            (!head_in_range || head_here);
    assign arrival_travel = (state == elevator_pkg::DISPATCH_TRAVEL) &&
                            (current_floor == target_floor);
    assign arrival        = run_en && !elevator_moving && (arrival_idle || arrival_travel);

    //////////////////////////////////////////////////////////////////////
    // Dispatch FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state             <= elevator_pkg::DISPATCH_IDLE;
            target_floor      <= '0;
            direction_up      <= 1'b0;
            activate_elevator <= 1'b0;
        end else if (!run_en) begin
            state             <= elevator_pkg::DISPATCH_IDLE;
            activate_elevator <= 1'b0;
        end else begin
            case (state)
                elevator_pkg::DISPATCH_IDLE: begin
                    if (start_travel) begin
                        state        <= elevator_pkg::DISPATCH_TRAVEL;
                        target_floor <= head_floor;
                    end
                end
                elevator_pkg::DISPATCH_TRAVEL: begin
                    if (arrival) begin
                        state             <= elevator_pkg::DISPATCH_IDLE;
                        activate_elevator <= 1'b0;
                    end else if (!activate_elevator) begin
                        // Direction fixed once, while the car is still at the start floor
                        activate_elevator <= 1'b1;
                        direction_up      <= (target_floor > current_floor);
                    end
                end
                default: state <= elevator_pkg::DISPATCH_IDLE;
            endcase
        end
    end

    // Door permissions
    assign door_gate = !elevator_moving && power_switch;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_open_btn && door_gate;
            door_close_allowed <= door_close_btn && door_gate;
        end
    end

endmodule

`default_nettype wire

// ==== logic/floor_request_controller.sv ====
// Floor request controller; needs an external motion sequencer reporting floor and motion
`default_nettype none
`timescale 1ns/100ps

module floor_request_controller #(
    parameter int num_floors  = elevator_pkg::NUM_FLOORS_DEFAULT,
    parameter int queue_depth = elevator_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire  [num_floors-1:0]       floor_call_buttons,
    input  wire  [num_floors-1:0]       panel_buttons,
    input  wire                         door_open_btn,
    input  wire                         door_close_btn,
    input  wire                         emergency_btn,
    input  wire                         power_switch,
    input  wire  elevator_pkg::floor_t  current_floor,
    input  wire                         elevator_moving,
    output elevator_pkg::floor_t        target_floor,
    output logic                        direction_up,
    output logic                        activate_elevator,
    output logic [num_floors-1:0]       call_button_lights,
    output logic [num_floors-1:0]       panel_button_lights,
    output logic                        door_open_allowed,
    output logic                        door_close_allowed
);

    logic                 request_valid;
    elevator_pkg::floor_t request_floor;
    elevator_pkg::floor_t head_floor;
    logic                 queue_empty;
    logic                 queue_full;
    logic                 arrival;

    request_latch #(
        .num_floors (num_floors)
    ) request_latch_inst (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .current_floor       (current_floor),
        .power_switch        (power_switch),
        .emergency_btn       (emergency_btn),
        .queue_full          (queue_full),
        .arrival             (arrival),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .request_valid       (request_valid),
        .request_floor       (request_floor)
    );

    request_queue #(
        .queue_depth (queue_depth)
    ) request_queue_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .request_valid (request_valid),
        .request_floor (request_floor),
        .arrival       (arrival),
        .power_switch  (power_switch),
        .head_floor    (head_floor),
        .queue_empty   (queue_empty),
        .queue_full    (queue_full)
    );

    dispatch_control #(
        .num_floors (num_floors)
    ) dispatch_control_inst (
        .clock              (clock),
        .reset_n            (reset_n),
        .head_floor         (head_floor),
        .queue_empty        (queue_empty),
        .current_floor      (current_floor),
        .elevator_moving    (elevator_moving),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .target_floor       (target_floor),
        .direction_up       (direction_up),
        .activate_elevator  (activate_elevator),
        .arrival            (arrival),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

`default_nettype wire

// ==== verif/floor_request_properties.sv ====
// Bound into dispatch_control; assertions are off while reset_n is low
`default_nettype none
`timescale 1ns/100ps

module floor_request_properties (
    input wire clock,
    input wire reset_n,
    input wire power_switch,
    input wire emergency_btn,
    input wire elevator_moving,
    input wire activate_elevator,
    input wire arrival,
    input wire door_open_allowed
);

    int activate_fails = 0;
    int arrival_fails  = 0;
    int door_fails     = 0;

    // Emergency or power off stops the car at the next edge
    activate_drop: assert property (@(posedge clock) disable iff (!reset_n)
        (emergency_btn || !power_switch) |=> !activate_elevator)
    else begin
        $error("activate_elevator high after emergency or power off");
        activate_fails++;
    end

    arrival_stopped: assert property (@(posedge clock) disable iff (!reset_n)
        elevator_moving |-> !arrival)
    else begin
        $error("arrival while the car is moving");
        arrival_fails++;
    end

    // Door permission is registered, so it lags the motion flag by one edge
    door_stopped: assert property (@(posedge clock) disable iff (!reset_n)
        elevator_moving |=> !door_open_allowed)
    else begin
        $error("door_open_allowed high right after motion");
        door_fails++;
    end

endmodule

bind dispatch_control floor_request_properties dispatch_properties_inst (
    .clock             (clock),
    .reset_n           (reset_n),
    .power_switch      (power_switch),
    .emergency_btn     (emergency_btn),
    .elevator_moving   (elevator_moving),
    .activate_elevator (activate_elevator),
    .arrival           (arrival),
    .door_open_allowed (door_open_allowed)
);

`default_nettype wire

// ==== verif/floor_request_controller_tb.sv ====
// Uses default sizes of 11 floors and a 16-entry queue; car travel time is random from a fixed seed
`default_nettype none
`timescale 1ns/100ps

module floor_request_controller_tb;

    localparam int num_floors      = elevator_pkg::NUM_FLOORS_DEFAULT;
    localparam int queue_depth     = elevator_pkg::QUEUE_DEPTH_DEFAULT;
    localparam int num_rows        = 8;
    localparam int max_trip        = 8;
    // Every row and each later scenario gets one worst trip plus slack
    localparam int watchdog_cycles = (num_rows + 12) * (max_trip + 20) + 100;

    typedef struct {
        string                name;
        bit                   panel;
        elevator_pkg::floor_t floor;
        elevator_pkg::floor_t start;
        bit                   light;
        bit                   dir_up;
    } row_t;

    logic                  clock = 1'b0;
    logic                  reset_n;
    logic [num_floors-1:0] floor_call_buttons;
    logic [num_floors-1:0] panel_buttons;
    logic                  door_open_btn;
    logic                  door_close_btn;
    logic                  emergency_btn;
    logic                  power_switch;
    elevator_pkg::floor_t  current_floor;
    logic                  elevator_moving;
    elevator_pkg::floor_t  target_floor;
    logic                  direction_up;
    logic                  activate_elevator;
    logic [num_floors-1:0] call_button_lights;
    logic [num_floors-1:0] panel_button_lights;
    logic                  door_open_allowed;
    logic                  door_close_allowed;

    row_t                  rows [num_rows];
    int                    check_count = 0;
    int                    error_count = 0;
    bit                    hold_car = 1'b0;
    bit                    place_car = 1'b0;
    elevator_pkg::floor_t  place_floor = '0;
    logic                  activate_q = 1'b0;
    elevator_pkg::floor_t  targets_seen [$];

    floor_request_controller #(
        .num_floors  (num_floors),
        .queue_depth (queue_depth)
    ) floor_request_controller_inst (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .door_open_btn       (door_open_btn),
        .door_close_btn      (door_close_btn),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .elevator_moving     (elevator_moving),
        .target_floor        (target_floor),
        .direction_up        (direction_up),
        .activate_elevator   (activate_elevator),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .door_open_allowed   (door_open_allowed),
        .door_close_allowed  (door_close_allowed)
    );

    always #5 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Car model, the only driver of current_floor and elevator_moving
    //////////////////////////////////////////////////////////////////////

    initial begin : car_model
        int trip;
        void'($urandom(32'h0896_3f4d));
        current_floor   = '0;
        elevator_moving = 1'b0;
        forever begin
            @(posedge clock);
            if (hold_car) begin
                elevator_moving <= 1'b1;
            end else if (place_car) begin
                current_floor   <= place_floor;
                elevator_moving <= 1'b0;
            end else begin
                elevator_moving <= 1'b0;
                if (activate_elevator && current_floor != target_floor) begin
                    trip = 3 + int'($urandom % 6);
                    elevator_moving <= 1'b1;
                    repeat (trip) @(posedge clock);
                    current_floor   <= target_floor;
                    elevator_moving <= 1'b0;
                end
            end
        end
    end

    // Target floor captured at every activate rise
    always @(posedge clock) begin
        if (activate_elevator && !activate_q) begin
            targets_seen.push_back(target_floor);
        end
        activate_q <= activate_elevator;
    end

    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // Moves the idle car to a floor, visible before the next press
    task automatic place_car_at(input elevator_pkg::floor_t floor);
        @(posedge clock);
        place_floor <= floor;
        place_car   <= 1'b1;
        @(posedge clock);
        place_car   <= 1'b0;
    endtask

    // Button held for one edge
    task automatic press_button(input logic panel, input elevator_pkg::floor_t floor);
        @(posedge clock);
        if (panel) begin
            panel_buttons[floor] <= 1'b1;
        end else begin
            floor_call_buttons[floor] <= 1'b1;
        end
        @(posedge clock);
        panel_buttons      <= '0;
        floor_call_buttons <= '0;
    endtask

    task automatic wait_activate(input logic level, input int max_cycles, output bit seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < max_cycles && !seen; n++) begin
            @(negedge clock);
            seen = (activate_elevator == level);
        end
    endtask

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("TB FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        bit                   ok;
        int                   cycles;
        int                   lit;
        int                   prop_fails;
        elevator_pkg::floor_t order [4];
        // name, panel, floor, start, light, direction_up
        rows[0] = '{"panel_up",   1'b1, 4'd5,  4'd0, 1'b1, 1'b1};
        rows[1] = '{"panel_down", 1'b1, 4'd2,  4'd7, 1'b1, 1'b0};
        rows[2] = '{"call_up",    1'b0, 4'd10, 4'd3, 1'b1, 1'b1};
        rows[3] = '{"call_down",  1'b0, 4'd0,  4'd9, 1'b1, 1'b0};
        rows[4] = '{"panel_here", 1'b1, 4'd4,  4'd4, 1'b0, 1'b0};
        rows[5] = '{"call_here",  1'b0, 4'd6,  4'd6, 1'b0, 1'b0};
        rows[6] = '{"panel_top",  1'b1, 4'd10, 4'd9, 1'b1, 1'b1};
        rows[7] = '{"call_low",   1'b0, 4'd1,  4'd2, 1'b1, 1'b0};
        order[0] = 4'd7;
        order[1] = 4'd3;
        order[2] = 4'd9;
        order[3] = 4'd1;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        repeat (10) @(posedge clock);
        reset_n <= 1'b1;

        // Single requests from the table
        for (int i = 0; i < num_rows; i++) begin
            place_car_at(rows[i].start);
            press_button(rows[i].panel, rows[i].floor);
            @(negedge clock);
            if (rows[i].panel) begin
                check_value({rows[i].name, " light"}, int'(rows[i].light),
                            int'(panel_button_lights[rows[i].floor]));
            end else begin
                check_value({rows[i].name, " light"}, int'(rows[i].light),
                            int'(call_button_lights[rows[i].floor]));
            end
            wait_activate(1'b1, 6, ok);
            check_value({rows[i].name, " activate"}, int'(rows[i].light), int'(ok));
            if (ok) begin
                check_value({rows[i].name, " direction"}, int'(rows[i].dir_up),
                            int'(direction_up));
                check_value({rows[i].name, " target"}, int'(rows[i].floor), int'(target_floor));
                wait_activate(1'b0, 2 * max_trip + 10, ok);
                check_value({rows[i].name, " arrival"}, 1, int'(ok));
                check_value({rows[i].name, " floor"}, int'(rows[i].floor), int'(current_floor));
                check_value({rows[i].name, " lights off"}, 0,
                            int'(panel_button_lights[rows[i].floor] |
                                 call_button_lights[rows[i].floor]));
            end
        end

        // Requests pressed during travel are served in press order
        place_car_at(4'd0);
        targets_seen.delete();
        press_button(1'b1, 4'd7);
        wait_activate(1'b1, 6, ok);
        check_value("order first activate", 1, int'(ok));
        press_button(1'b0, 4'd3);
        press_button(1'b1, 4'd9);
        press_button(1'b0, 4'd1);
        cycles = 0;
        while (targets_seen.size() < 4 && cycles < 4 * (max_trip + 10)) begin
            @(negedge clock);
            cycles++;
        end
        wait_activate(1'b0, 2 * max_trip + 10, ok);
        check_value("order trip count", 4, targets_seen.size());
        for (int k = 0; k < 4 && k < targets_seen.size(); k++) begin
            check_value("order target", int'(order[k]), int'(targets_seen[k]));
        end

        // Car held moving while every other button is pressed
        @(posedge clock);
        hold_car <= 1'b1;
        @(posedge clock);
        panel_buttons      <= ~(num_floors'(1) << current_floor);
        floor_call_buttons <= ~(num_floors'(1) << current_floor);
        cycles = 0;
        lit    = 0;
        while (lit < queue_depth && cycles < 40) begin
            @(negedge clock);
            lit = $countones({call_button_lights, panel_button_lights});
            cycles++;
        end
        repeat (3) @(negedge clock);
        check_value("full queue lights", queue_depth,
                    $countones({call_button_lights, panel_button_lights}));

        // Power cycle flushes lights and queue
        @(posedge clock);
        panel_buttons      <= '0;
        floor_call_buttons <= '0;
        power_switch       <= 1'b0;
        @(posedge clock);
        power_switch <= 1'b1;
        hold_car     <= 1'b0;
        @(negedge clock);
        check_value("power off lights", 0,
                    $countones({call_button_lights, panel_button_lights}));
        check_value("power off activate", 0, int'(activate_elevator));
        wait_activate(1'b1, 8, ok);
        check_value("power on no activate", 0, int'(ok));

        // Emergency blocks new requests
        @(posedge clock);
        emergency_btn <= 1'b1;
        press_button(1'b1, 4'd6);
        @(negedge clock);
        check_value("emergency light", 0, int'(panel_button_lights[6]));
        wait_activate(1'b1, 8, ok);
        check_value("emergency activate", 0, int'(ok));
        @(posedge clock);
        emergency_btn <= 1'b0;
        wait_activate(1'b1, 8, ok);
        check_value("emergency release activate", 0, int'(ok));

        // Door permissions follow buttons only while stopped
        @(posedge clock);
        door_open_btn <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        check_value("door open stopped", 1, int'(door_open_allowed));
        check_value("door close idle", 0, int'(door_close_allowed));
        @(posedge clock);
        door_open_btn  <= 1'b0;
        door_close_btn <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        check_value("door open idle", 0, int'(door_open_allowed));
        check_value("door close stopped", 1, int'(door_close_allowed));
        @(posedge clock);
        hold_car <= 1'b1;
        repeat (2) @(posedge clock);
        door_open_btn <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        check_value("door open moving", 0, int'(door_open_allowed));
        check_value("door close moving", 0, int'(door_close_allowed));
        @(posedge clock);
        hold_car       <= 1'b0;
        door_open_btn  <= 1'b0;
        door_close_btn <= 1'b0;
        repeat (2) @(posedge clock);

        prop_fails =
            floor_request_controller_inst.dispatch_control_inst.dispatch_properties_inst.activate_fails +
            floor_request_controller_inst.dispatch_control_inst.dispatch_properties_inst.arrival_fails +
            floor_request_controller_inst.dispatch_control_inst.dispatch_properties_inst.door_fails;
        if (prop_fails > 0) begin
            $display("Dispatch assertions failed %0d times", prop_fails);
        end
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, prop_fails);
        if (error_count == 0 && prop_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/elevator_pkg.sv
logic/request_latch.sv
logic/request_queue.sv
logic/dispatch_control.sv
logic/floor_request_controller.sv
verif/floor_request_properties.sv
verif/floor_request_controller_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the floor request controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module floor_request_controller_tb \
    -f list.f \
    --Mdir obj_dir \
    -o floor_request_controller_tb

# Assertion errors are counted by the testbench, so the run must not stop at the first one
./obj_dir/floor_request_controller_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
